// ==== source/host_if_pkg.sv ====
`default_nettype none

package host_if_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    // Internal bus address and one data or character byte
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  byte_t;

    // Receive line buffer, first received character in the low byte
    localparam int LINE_BYTES = 16;
    typedef logic [LINE_BYTES*8-1:0] line_t;

    // ------------------------------------------------------------------------
    // Bus timing and reply sizing
    // ------------------------------------------------------------------------
    // Cycles from the read strobe to valid read data
    localparam int READ_LATENCY = 4;
    localparam int LAT_W        = $clog2(READ_LATENCY + 1);

    // Longest reply is "OK" LF hi lo LF
    localparam int REPLY_BYTES = 6;

    // Run-control register and the values written by stop / start
    localparam addr_t CTRL_ADDR  = 16'h0000;
    localparam byte_t STOP_DATA  = 8'h01;
    localparam byte_t START_DATA = 8'h00;

    // Characters
    localparam byte_t CHAR_LF  = 8'h0A;
    localparam byte_t CHAR_SP  = 8'h20;
    localparam byte_t CHAR_NUL = 8'h00;

    // ------------------------------------------------------------------------
    // Command, bus and reply types
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        CMD_WR,
        CMD_RD,
        CMD_STOP,
        CMD_START,
        CMD_BAD
    } cmd_kind_e;

    typedef struct packed {
        cmd_kind_e kind;
        addr_t     addr;
        byte_t     wdata;
    } cmd_t;

    typedef struct packed {
        addr_t addr;
        byte_t wdata;
        logic  we;
        logic  re;
    } bus_req_t;

    typedef enum logic [1:0] {
        REPLY_NONE,
        REPLY_OK,
        REPLY_NG,
        REPLY_RD
    } reply_e;

    // Sequencer states
    typedef enum logic [1:0] {
        S_IDLE,
        S_BUS,
        S_REPLY,
        S_CLEAR
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== source/cmd_decoder.sv ====
`default_nettype none

module cmd_decoder (
    input  wire host_if_pkg::line_t line,
    output host_if_pkg::cmd_t       cmd
);
    import host_if_pkg::*;

    byte_t [LINE_BYTES-1:0] ch;
    byte_t [LINE_BYTES-1:0] lc;
    logic  [4:0]            h3, h4, h5, h6, h8, h9;
    logic                   addr_ok;
    logic                   data_ok;
    addr_t                  addr_val;
    byte_t                  data_val;
    logic                   is_wr, is_rd, is_stop, is_start;

    // Letters only, so separators and digits pass unchanged
    function automatic byte_t fold_case(input byte_t c);
        if (c >= "A" && c <= "Z") begin
            return c | 8'h20;
        end
        return c;
    endfunction

    // Bit 4 flags a valid digit; expects a case-folded character
    function automatic logic [4:0] hex_digit(input byte_t c);
        if (c >= "0" && c <= "9") begin
            return {1'b1, c[3:0]};
        end
        if (c >= "a" && c <= "f") begin
            return {1'b1, c[3:0] + 4'd9};
        end
        return 5'b0_0000;
    endfunction

    assign ch = line;

    always_comb begin
        for (int i = 0; i < LINE_BYTES; i++) begin
            lc[i] = fold_case(ch[i]);
        end
    end

    // ------------------------------------------------------------------------
    // Hex fields, address in bytes 3..6 and data in bytes 8..9
    // ------------------------------------------------------------------------
    assign h3 = hex_digit(lc[3]);
    assign h4 = hex_digit(lc[4]);
    assign h5 = hex_digit(lc[5]);
    assign h6 = hex_digit(lc[6]);
    assign h8 = hex_digit(lc[8]);
    assign h9 = hex_digit(lc[9]);

    assign addr_ok  = h3[4] && h4[4] && h5[4] && h6[4];
    assign data_ok  = h8[4] && h9[4];
    assign addr_val = {h3[3:0], h4[3:0], h5[3:0], h6[3:0]};
    assign data_val = {h8[3:0], h9[3:0]};

    // Keywords, case-insensitive per character
    assign is_stop  = ({lc[0], lc[1], lc[2], lc[3]} == "stop");
    assign is_start = ({lc[0], lc[1], lc[2], lc[3], lc[4]} == "start");
    assign is_rd    = ({lc[0], lc[1], lc[2]} == "rd ") && (ch[7] == CHAR_LF) && addr_ok;
    assign is_wr    = ({lc[0], lc[1], lc[2]} == "wr ") && (ch[7] == CHAR_SP)
                      && (ch[10] == CHAR_LF) && addr_ok && data_ok;

    always_comb begin
        cmd.kind  = CMD_BAD;
        cmd.addr  = addr_val;
        cmd.wdata = data_val;
        if (is_stop) begin
            cmd.kind  = CMD_STOP;
            cmd.addr  = CTRL_ADDR;
            cmd.wdata = STOP_DATA;
        end else if (is_start) begin
            cmd.kind  = CMD_START;
            cmd.addr  = CTRL_ADDR;
            cmd.wdata = START_DATA;
        end else if (is_rd) begin
            cmd.kind = CMD_RD;
        end else if (is_wr) begin
            cmd.kind = CMD_WR;
        end
    end

endmodule

`default_nettype wire

// ==== source/host_ctrl.sv ====
`default_nettype none

module host_ctrl (
    input  wire logic                CLK,
    input  wire logic                RST_N,
    input  wire logic                line_valid,
    input  wire host_if_pkg::cmd_t   cmd,
    output logic                     bus_start,
    output host_if_pkg::cmd_t        bus_cmd,
    input  wire logic                bus_done,
    output logic                     reply_start,
    output host_if_pkg::reply_e      reply_kind,
    input  wire logic                reply_done,
    output logic                     buf_clr
);
    import host_if_pkg::*;

    ctrl_state_e state;
    logic        line_valid_q;
    logic        trig;
    reply_e      reply_sel;

    // New line only on a rising edge, later edges are dropped while busy
    assign trig    = line_valid && !line_valid_q;
    assign buf_clr = (state == S_CLEAR);

    always_comb begin
        case (cmd.kind)
            CMD_RD:    reply_sel = REPLY_RD;
            CMD_START: reply_sel = REPLY_NONE;
            CMD_BAD:   reply_sel = REPLY_NG;
            default:   reply_sel = REPLY_OK;
        endcase
    end

    // ------------------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state        <= S_IDLE;
            line_valid_q <= 1'b0;
            bus_start    <= 1'b0;
            reply_start  <= 1'b0;
            reply_kind   <= REPLY_NONE;
        end else begin
            line_valid_q <= line_valid;
            bus_start    <= 1'b0;
            reply_start  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (trig) begin
                        reply_kind <= reply_sel;
                        // Bad lines go straight to the NG reply
                        if (cmd.kind == CMD_BAD) begin
                            reply_start <= 1'b1;
                            state       <= S_REPLY;
                        end else begin
                            bus_start <= 1'b1;
                            state     <= S_BUS;
                        end
                    end
                end
                S_BUS: begin
                    if (bus_done) begin
                        reply_start <= 1'b1;
                        state       <= S_REPLY;
                    end
                end
                S_REPLY: begin
                    if (reply_done) begin
                        state <= S_CLEAR;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Command held for the whole bus phase
    always_ff @(posedge CLK) begin
        if (state == S_IDLE && trig) begin
            bus_cmd <= cmd;
        end
    end

    // Done strobes only arrive in the phase that waits for them
    a_phase_done: assert property (@(posedge CLK) disable iff (!RST_N)
        (!bus_done || state == S_BUS) && (!reply_done || state == S_REPLY));

endmodule

`default_nettype wire

// ==== source/bus_access.sv ====
`default_nettype none

module bus_access (
    input  wire logic                     CLK,
    input  wire logic                     RST_N,
    input  wire logic                     bus_start,
    input  wire host_if_pkg::cmd_t        bus_cmd,
    output host_if_pkg::bus_req_t         bus,
    input  wire host_if_pkg::byte_t       bus_rdata,
    output logic                          bus_done,
    output host_if_pkg::byte_t [1:0]      rd_ascii
);
    import host_if_pkg::*;

    logic [LAT_W-1:0] lat_cnt;
    logic             sample;
    byte_t            rdata_q;

    // Upper-case hex character for one nibble
    function automatic byte_t to_ascii(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h37 + {4'h0, nib};
    endfunction

    // ------------------------------------------------------------------------
    // Strobes, one cycle per command
    // ------------------------------------------------------------------------
    always_comb begin
        bus.addr  = bus_cmd.addr;
        bus.wdata = bus_cmd.wdata;
        bus.re    = bus_start && (bus_cmd.kind == CMD_RD);
        bus.we    = bus_start && (bus_cmd.kind == CMD_WR || bus_cmd.kind == CMD_STOP
                                  || bus_cmd.kind == CMD_START);
    end

    // Read data valid READ_LATENCY cycles after re
    assign sample = (lat_cnt == LAT_W'(1));

    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            lat_cnt  <= '0;
            bus_done <= 1'b0;
        end else begin
            if (bus.re) begin
                lat_cnt <= LAT_W'(READ_LATENCY);
            end else if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
            bus_done <= bus.we || sample;
        end
    end

    always_ff @(posedge CLK) begin
        if (sample) begin
            rdata_q <= bus_rdata;
        end
    end

    // High digit in element 1, sent first
    assign rd_ascii = {to_ascii(rdata_q[7:4]), to_ascii(rdata_q[3:0])};

    // No new access while a read is still waiting for its data
    a_no_overlap: assert property (@(posedge CLK) disable iff (!RST_N)
        bus_start |-> lat_cnt == '0);

    a_read_done: assert property (@(posedge CLK) disable iff (!RST_N)
        bus.re |-> ##(READ_LATENCY + 1) bus_done);

endmodule

`default_nettype wire

// ==== source/reply_tx.sv ====
`default_nettype none

module reply_tx (
    input  wire logic                     CLK,
    input  wire logic                     RST_N,
    input  wire logic                     reply_start,
    input  wire host_if_pkg::reply_e      reply_kind,
    input  wire host_if_pkg::byte_t [1:0] rd_ascii,
    output logic                          tx_valid,
    output host_if_pkg::byte_t            tx_data,
    input  wire logic                     tx_busy,
    output logic                          reply_done
);
    import host_if_pkg::*;

    typedef enum logic [1:0] {
        T_IDLE,
        T_SEND,
        T_WAIT_BUSY,
        T_WAIT_READY
    } tx_state_e;

    tx_state_e                state;
    byte_t [REPLY_BYTES-1:0]  queue;
    byte_t [REPLY_BYTES-1:0]  msg;
    logic                     send;

    // Byte 0 goes out first, a NUL ends the message
    always_comb begin
        case (reply_kind)
            REPLY_OK: msg = {CHAR_NUL, CHAR_NUL, CHAR_NUL, CHAR_LF, "K", "O"};
            REPLY_NG: msg = {CHAR_NUL, CHAR_NUL, CHAR_NUL, CHAR_LF, "G", "N"};
            REPLY_RD: msg = {CHAR_LF, rd_ascii[0], rd_ascii[1], CHAR_LF, "K", "O"};
            default:  msg = '0;
        endcase
    end

    assign send = (state == T_SEND) && (queue[0] != CHAR_NUL) && !tx_busy;

    // ------------------------------------------------------------------------
    // Send / wait busy / wait ready
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state      <= T_IDLE;
            tx_valid   <= 1'b0;
            reply_done <= 1'b0;
        end else begin
            reply_done <= 1'b0;
            case (state)
                T_IDLE: begin
                    if (reply_start) begin
                        state <= T_SEND;
                    end
                end
                T_SEND: begin
                    if (queue[0] == CHAR_NUL) begin
                        reply_done <= 1'b1;
                        state      <= T_IDLE;
                    end else if (send) begin
                        tx_valid <= 1'b1;
                        state    <= T_WAIT_BUSY;
                    end
                end
                T_WAIT_BUSY: begin
                    if (tx_busy) begin
                        tx_valid <= 1'b0;
                        state    <= T_WAIT_READY;
                    end
                end
                default: begin
                    if (!tx_busy) begin
                        state <= T_SEND;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == T_IDLE && reply_start) begin
            queue <= msg;
        end else if (send) begin
            tx_data <= queue[0];
            queue   <= {CHAR_NUL, queue[REPLY_BYTES-1:1]};
        end
    end

    a_data_stable: assert property (@(posedge CLK) disable iff (!RST_N)
        tx_valid && $past(tx_valid) |-> $stable(tx_data));

endmodule

`default_nettype wire

// ==== source/host_if_top.sv ====
`default_nettype none

module host_if_top (
    input  wire logic                 CLK,
    input  wire logic                 RST_N,
    input  wire host_if_pkg::line_t   line,
    input  wire logic                 line_valid,
    output logic                      buf_clr,
    output host_if_pkg::bus_req_t     bus,
    input  wire host_if_pkg::byte_t   bus_rdata,
    output logic                      tx_valid,
    output host_if_pkg::byte_t        tx_data,
    input  wire logic                 tx_busy
);
    import host_if_pkg::*;

    cmd_t        cmd;
    cmd_t        bus_cmd;
    logic        bus_start;
    logic        bus_done;
    byte_t [1:0] rd_ascii;
    logic        reply_start;
    reply_e      reply_kind;
    logic        reply_done;

    cmd_decoder u_cmd_decoder (
        .line (line),
        .cmd  (cmd)
    );

    host_ctrl u_host_ctrl (
        .CLK         (CLK),
        .RST_N       (RST_N),
        .line_valid  (line_valid),
        .cmd         (cmd),
        .bus_start   (bus_start),
        .bus_cmd     (bus_cmd),
        .bus_done    (bus_done),
        .reply_start (reply_start),
        .reply_kind  (reply_kind),
        .reply_done  (reply_done),
        .buf_clr     (buf_clr)
    );

    bus_access u_bus_access (
        .CLK       (CLK),
        .RST_N     (RST_N),
        .bus_start (bus_start),
        .bus_cmd   (bus_cmd),
        .bus       (bus),
        .bus_rdata (bus_rdata),
        .bus_done  (bus_done),
        .rd_ascii  (rd_ascii)
    );

    reply_tx u_reply_tx (
        .CLK         (CLK),
        .RST_N       (RST_N),
        .reply_start (reply_start),
        .reply_kind  (reply_kind),
        .rd_ascii    (rd_ascii),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data),
        .tx_busy     (tx_busy),
        .reply_done  (reply_done)
    );

endmodule

`default_nettype wire

// ==== sim/tb_host_if.sv ====
`default_nettype none

module tb_host_if;
    import host_if_pkg::*;

    localparam int          CLK_PERIOD = 10;
    localparam int          MAX_CMDS   = 200;
    localparam int          CMD_CYCLES = 200;
    localparam int          N_LOOP     = 40;
    localparam logic [31:0] SEED       = 32'hb3553b7d;

    logic     CLK;
    logic     RST_N;
    line_t    line;
    logic     line_valid;
    logic     buf_clr;
    bus_req_t bus;
    byte_t    bus_rdata;
    logic     tx_valid;
    byte_t    tx_data;
    logic     tx_busy;

    byte_t    mem    [0:65535];
    byte_t    shadow [0:65535];
    byte_t    rx_q   [$];
    byte_t    uart_byte;
    addr_t    rd_addr;
    int       rd_cnt;
    int       we_cnt;
    int       re_cnt;
    int       clr_cnt;
    int       clr_total;
    int       cmds_done;
    addr_t    we_addr;
    addr_t    re_addr;
    byte_t    we_data;
    string    test_name;

    host_if_top u_host_if_top (
        .CLK        (CLK),
        .RST_N      (RST_N),
        .line       (line),
        .line_valid (line_valid),
        .buf_clr    (buf_clr),
        .bus        (bus),
        .bus_rdata  (bus_rdata),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .tx_busy    (tx_busy)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // Power-up contents, every address bit takes part
    function automatic byte_t fill_byte(input addr_t a);
        return a[15:8] ^ {a[6:0], a[7]} ^ 8'hc3;
    endfunction

    // Random upper case on letters, host may type either
    function automatic string rand_case(input string s);
        string r;
        int    i;
        r = s;
        for (i = 0; i < r.len(); i++) begin
            if (r[i] >= "a" && r[i] <= "z" && $urandom_range(0, 1) == 1) begin
                r[i] = r[i] - 8'h20;
            end
        end
        return r;
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_val(input string what, input int exp, input int act);
        assert (exp == act) else begin
            $display("Error: %s: %s expected %0h actual %0h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // Bus memory and UART models
    // ------------------------------------------------------------------------
    always @(posedge CLK) begin
        if (bus.we) begin
            mem[bus.addr] <= bus.wdata;
        end
        if (bus.re) begin
            rd_cnt  <= READ_LATENCY;
            rd_addr <= bus.addr;
        end else if (rd_cnt != 0) begin
            rd_cnt <= rd_cnt - 1;
        end
    end

    // Noise outside the sampling cycle
    always @(negedge CLK) begin
        bus_rdata <= (rd_cnt == 1) ? mem[rd_addr] : byte_t'($urandom);
    end

    always begin
        @(negedge CLK);
        if (RST_N && tx_valid) begin
            uart_byte = tx_data;
            repeat ($urandom_range(1, 3)) @(negedge CLK);
            tx_busy = 1'b1;
            rx_q.push_back(uart_byte);
            repeat ($urandom_range(2, 8)) @(negedge CLK);
            tx_busy = 1'b0;
        end
    end

    // Strobe and clear monitor
    always @(posedge CLK) begin
        if (RST_N) begin
            if (bus.we) begin
                we_cnt  = we_cnt + 1;
                we_addr = bus.addr;
                we_data = bus.wdata;
            end
            if (bus.re) begin
                re_cnt  = re_cnt + 1;
                re_addr = bus.addr;
            end
            if (buf_clr) begin
                clr_cnt   = clr_cnt + 1;
                clr_total = clr_total + 1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Protocol assertions
    // ------------------------------------------------------------------------
    a_tx_rise: assert property (@(posedge CLK) disable iff (!RST_N)
        $rose(tx_valid) |-> !$past(tx_busy))
        else begin
            $display("Error: %s: tx_valid rose while tx_busy was high", test_name);
            abort_run();
        end

    a_tx_held: assert property (@(posedge CLK) disable iff (!RST_N)
        tx_valid && !tx_busy |=> tx_valid)
        else begin
            $display("Error: %s: tx_valid dropped before tx_busy was seen", test_name);
            abort_run();
        end

    a_clr_pulse: assert property (@(posedge CLK) disable iff (!RST_N)
        buf_clr |=> !buf_clr)
        else begin
            $display("Error: %s: buf_clr was longer than one cycle", test_name);
            abort_run();
        end

    a_clr_after_tx: assert property (@(posedge CLK) disable iff (!RST_N)
        buf_clr |-> !tx_valid && !tx_busy)
        else begin
            $display("Error: %s: buf_clr came before the reply ended", test_name);
            abort_run();
        end

    a_strobe_pulse: assert property (@(posedge CLK) disable iff (!RST_N)
        (bus.we || bus.re) |=> !(bus.we || bus.re))
        else begin
            $display("Error: %s: bus strobe longer than one cycle", test_name);
            abort_run();
        end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic run_cmd(input string name, input string text, input int exp_we,
                           input int exp_re, input addr_t exp_addr, input byte_t exp_data,
                           input string exp_reply);
        line_t ln;
        int    i;
        ln = '0;
        for (i = 0; i < text.len() && i < LINE_BYTES; i++) begin
            ln[i*8 +: 8] = text[i];
        end
        test_name = $sformatf("%s #%0d", name, cmds_done);
        we_cnt    = 0;
        re_cnt    = 0;
        clr_cnt   = 0;
        rx_q.delete();
        @(negedge CLK);
        line       = ln;
        line_valid = 1'b1;
        @(negedge CLK);
        while (!buf_clr) begin
            @(negedge CLK);
        end
        line_valid = 1'b0;
        check_val("reply length", exp_reply.len(), rx_q.size());
        for (i = 0; i < exp_reply.len(); i++) begin
            check_val($sformatf("reply byte %0d", i), exp_reply[i], rx_q[i]);
        end
        repeat (4) @(negedge CLK);
        check_val("we pulses", exp_we, we_cnt);
        check_val("re pulses", exp_re, re_cnt);
        check_val("buf_clr pulses", 1, clr_cnt);
        if (exp_we != 0) begin
            check_val("write address", exp_addr, we_addr);
            check_val("write data", exp_data, we_data);
            shadow[exp_addr] = exp_data;
        end
        if (exp_re != 0) begin
            check_val("read address", exp_addr, re_addr);
        end
        cmds_done = cmds_done + 1;
    endtask

    task automatic do_write(input addr_t a, input byte_t d);
        run_cmd("write", rand_case($sformatf("wr %04h %02h\n", a, d)), 1, 0, a, d, "OK\n");
    endtask

    task automatic do_read(input addr_t a);
        string hex;
        hex = $sformatf("%02h", shadow[a]);
        hex = hex.toupper();
        run_cmd("read", rand_case($sformatf("rd %04h\n", a)), 0, 1, a, 8'h00,
                {"OK\n", hex, "\n"});
    endtask

    task automatic do_bad(input string text);
        run_cmd("bad line", text, 0, 0, 16'h0000, 8'h00, "NG\n");
    endtask

    initial begin
        #(MAX_CMDS * CMD_CYCLES * CLK_PERIOD);
        $display("Error: watchdog expired, a command never finished");
        abort_run();
    end

    initial begin
        addr_t a;
        int    n;
        void'($urandom(SEED));
        CLK        = 1'b0;
        RST_N      = 1'b0;
        line       = '0;
        line_valid = 1'b0;
        bus_rdata  = 8'h00;
        tx_busy    = 1'b0;
        rd_cnt     = 0;
        clr_total  = 0;
        cmds_done  = 0;
        for (n = 0; n < 65536; n++) begin
            mem[n]    = fill_byte(addr_t'(n));
            shadow[n] = fill_byte(addr_t'(n));
        end
        repeat (10) @(negedge CLK);
        assert (!tx_valid && !buf_clr && !bus.we && !bus.re) else begin
            $display("Error: outputs not idle during reset");
            abort_run();
        end
        RST_N = 1'b1;
        repeat (3) @(negedge CLK);

        // Write then read back, some reads hit untouched memory
        for (n = 0; n < N_LOOP; n++) begin
            a = addr_t'($urandom);
            do_write(a, byte_t'($urandom));
            do_read(a);
            if (n % 4 == 0) begin
                do_read(addr_t'($urandom));
            end
        end

        run_cmd("stop", rand_case("stop\n"), 1, 0, CTRL_ADDR, 8'h01, "OK\n");
        do_read(CTRL_ADDR);
        run_cmd("start", rand_case("start\n"), 1, 0, CTRL_ADDR, 8'h00, "");
        do_read(CTRL_ADDR);

        do_bad("xy 1234\n");
        do_bad(rand_case("wr 12g4 56\n"));
        do_bad(rand_case("wr 1234-56\n"));
        do_bad(rand_case("wr 1234 5z\n"));
        do_bad(rand_case("rd 1234 \n"));
        do_bad(rand_case("rd 12g4\n"));

        if (cmds_done > 0 && clr_total == cmds_done) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Error: %0d buf_clr pulses for %0d commands", clr_total, cmds_done);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
source/host_if_pkg.sv
source/cmd_decoder.sv
source/host_ctrl.sv
source/bus_access.sv
source/reply_tx.sv
source/host_if_top.sv
sim/tb_host_if.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_host_if -f list.f &&
./obj_dir/Vtb_host_if | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "run.sh: simulation passed" && exit 0 ||
{ echo "run.sh: simulation failed"; exit 1; }
